// File: common/pce_io_pkg.sv
// Shared widths, constants and packed structs for pad, mouse and audio paths
package pce_io_pkg;

	// ========================================
	// Widths and constants
	// ========================================
	localparam int N_PADS     = 5;  // Multitap ports with real pads
	localparam int PAD_W      = 16;
	localparam int JOY_W      = 32;
	localparam int MIX_W      = 22; // Audio sum, two guard bits over 20
	localparam int DAC_W      = 19;
	localparam int MOUSE_TO_W = 15;

	localparam logic [PAD_W-1:0] PAD_IDLE = 16'h0FFF; // Ports 5 to 7

	// ========================================
	// Pad side
	// ========================================
	// Active low, top nibble always 0
	typedef struct packed {
		logic [3:0] rsv;
		logic [3:0] ext;   // Extra buttons, six-button page
		logic       left;
		logic       down;
		logic       right;
		logic       up;
		logic [3:0] btn;   // Run, select, II, I
	} pad_word_t;

	typedef struct packed {
		logic clr;
		logic sel;
	} pad_ctrl_t;

	typedef struct packed {
		logic swap;
		logic turbotap;
		logic buttons6;
		logic mouse_en;
	} pad_cfg_t;

	typedef struct packed {
		logic [7:0] dx;
		logic [7:0] dy;
		logic       left;
		logic       right;
	} mouse_pkt_t;

	// ========================================
	// Audio side
	// ========================================
	typedef struct packed {
		logic signed [19:0] psg_l;
		logic signed [19:0] psg_r;
		logic signed [19:0] cdda_l;
		logic signed [19:0] cdda_r;
		logic signed [15:0] adpcm;  // Shared by both channels
	} audio_src_t;

	typedef logic [DAC_W-1:0] dac_word_t; // Offset binary

endpackage

// File: pad/pad_decode.sv
// Player swap and host joystick word to active-low pad word mapping
`timescale 1ns/1ps

module pad_decode (
	input  logic [pce_io_pkg::JOY_W-1:0] joy [pce_io_pkg::N_PADS],
	input  pce_io_pkg::pad_cfg_t         cfg,
	output pce_io_pkg::pad_word_t        pads [pce_io_pkg::N_PADS],
	output logic [1:0]                   pad0_btn
);
	import pce_io_pkg::*;

	logic [JOY_W-1:0] joy_sw [N_PADS];

	// Host bits: 0 right, 1 left, 2 down, 3 up, 7:4 buttons, 11:8 extra
	function automatic pad_word_t map_pad(input logic [JOY_W-1:0] j);
		pad_word_t p;
		p.rsv   = 4'h0;
		p.ext   = ~j[11:8];
		p.left  = ~j[1];
		p.down  = ~j[2];
		p.right = ~j[0];
		p.up    = ~j[3];
		p.btn   = ~j[7:4];
		return p;
	endfunction

	always_comb begin
		for (int i = 0; i < N_PADS; i++) begin
			joy_sw[i] = joy[i];
		end
		if (cfg.swap) begin  // Only players 1 and 2 trade places
			joy_sw[0] = joy[1];
			joy_sw[1] = joy[0];
		end
	end

	always_comb begin
		for (int i = 0; i < N_PADS; i++) begin
			pads[i] = map_pad(joy_sw[i]);
		end
	end

	assign pad0_btn = joy_sw[0][7:6]; // Mouse buttons come from here too

endmodule

// File: pad/mouse_tracker.sv
// Mouse delta capture, nibble read counter and read timeout
`timescale 1ns/1ps

module mouse_tracker (
	input  logic                   clk_sys,
	input  logic                   rst_n,
	input  pce_io_pkg::mouse_pkt_t mouse,
	input  logic                   mouse_strobe,
	input  pce_io_pkg::pad_ctrl_t  ctrl,
	input  logic [1:0]             pad0_btn,
	output logic [7:0]             mouse_nib
);
	import pce_io_pkg::*;

	logic                  clr_q;
	logic                  clr_rise;
	logic [MOUSE_TO_W-1:0] mouse_to;  // Cycles since clr was last high
	logic [1:0]            cnt;       // Nibble read position
	logic [7:0]            pend_x;
	logic [7:0]            pend_y;
	logic [7:0]            shown_x;
	logic [7:0]            shown_y;

	assign clr_rise = ctrl.clr & ~clr_q;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			clr_q    <= 1'b0;
			mouse_to <= '0;
		end else begin
			clr_q <= ctrl.clr;
			if (ctrl.clr)
				mouse_to <= '0;
			else if (~&mouse_to)
				mouse_to <= mouse_to + 1'b1; // Saturates
		end
	end

	// ========================================
	// Read count and delta hand-over
	// ========================================
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			cnt     <= 2'd3;
			pend_x  <= '0;
			pend_y  <= '0;
			shown_x <= '0;
			shown_y <= '0;
		end else begin
			if (&mouse_to)
				cnt <= 2'd3;  // Host gave up mid-sequence
			if (clr_rise) begin
				cnt <= cnt + 1'b1;
				if (cnt == 2'd3) begin  // New sequence starts
					shown_x <= pend_x;
					shown_y <= pend_y;
					pend_x  <= '0;
					pend_y  <= '0;
				end
			end
			// A fresh packet wins over the clear above
			if (mouse_strobe) begin
				pend_x <= 8'd0 - mouse.dx; // Console X runs the other way
				pend_y <= mouse.dy;
			end
		end
	end

	always_comb begin
		case (cnt)
			2'd0: mouse_nib[7:4] = shown_x[7:4];
			2'd1: mouse_nib[7:4] = shown_x[3:0];
			2'd2: mouse_nib[7:4] = shown_y[7:4];
			default: mouse_nib[7:4] = shown_y[3:0];
		endcase
	end

	assign mouse_nib[3:0] = ~{pad0_btn, mouse.left, mouse.right};

	// Timeout always lands the next read on x high
	a_timeout_cnt: assert property (@(posedge clk_sys) disable iff (!rst_n)
		(&mouse_to && !clr_rise) |=> (cnt == 2'd3));

endmodule

// File: pad/pad_port_mux.sv
// Multitap port counter, six-button page and registered pad nibble
`timescale 1ns/1ps

module pad_port_mux (
	input  logic                  clk_sys,
	input  logic                  rst_n,
	input  pce_io_pkg::pad_ctrl_t ctrl,
	input  pce_io_pkg::pad_cfg_t  cfg,
	input  pce_io_pkg::pad_word_t pads [pce_io_pkg::N_PADS],
	input  logic [7:0]            mouse_nib,
	output logic [3:0]            joy_in
);
	import pce_io_pkg::*;

	pad_ctrl_t        ctrl_q;
	logic [2:0]       port;     // Multitap position 0 to 7
	logic             page;     // Six-button extra page
	logic [PAD_W-1:0] word;
	logic [1:0]       nib_idx;

	// ========================================
	// Word select
	// ========================================
	always_comb begin
		if (port == 3'd0 && cfg.mouse_en)
			word = {mouse_nib, mouse_nib};
		else if (port < N_PADS)
			word = pads[port];
		else
			word = PAD_IDLE;  // Empty multitap slots
	end

	assign nib_idx = {page, ctrl.sel};

	// ========================================
	// Control edges and nibble register
	// ========================================
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			ctrl_q <= '0;
			port   <= '0;
			page   <= 1'b0;
			joy_in <= '0;
		end else begin
			ctrl_q <= ctrl;
			if (ctrl.clr) begin
				port   <= '0;
				joy_in <= '0;
				if (!ctrl_q.clr)
					page <= ~page;
			end else begin
				joy_in <= word[{nib_idx, 2'b00} +: 4];
				if (ctrl.sel && !ctrl_q.sel && cfg.turbotap)
					port <= port + 1'b1;
			end
			if (!cfg.buttons6)
				page <= 1'b0;  // Two-button pads never see the extra page
		end
	end

	// Console reads 0 during a clear
	a_clr_zero: assert property (@(posedge clk_sys) disable iff (!rst_n)
		ctrl.clr |=> (joy_in == 4'h0));

endmodule

// File: audio/audio_mixer.sv
// PSG, CD-DA and ADPCM summing with clamp to offset-binary converter range
`timescale 1ns/1ps

module audio_mixer (
	input  logic                   clk_sys,
	input  logic                   rst_n,
	input  pce_io_pkg::audio_src_t audio,
	output pce_io_pkg::dac_word_t  dac_l,
	output pce_io_pkg::dac_word_t  dac_r
);
	import pce_io_pkg::*;

	logic [MIX_W-1:0] psg_l_x;
	logic [MIX_W-1:0] psg_r_x;
	logic [MIX_W-1:0] cdda_l_x;
	logic [MIX_W-1:0] cdda_r_x;
	logic [MIX_W-1:0] adpcm_x;
	logic [MIX_W-1:0] sum_l;
	logic [MIX_W-1:0] sum_r;

	// Sign extension to the sum width
	assign psg_l_x  = {{(MIX_W-20){audio.psg_l[19]}}, audio.psg_l};
	assign psg_r_x  = {{(MIX_W-20){audio.psg_r[19]}}, audio.psg_r};
	assign cdda_l_x = {{(MIX_W-20){audio.cdda_l[19]}}, audio.cdda_l};
	assign cdda_r_x = {{(MIX_W-20){audio.cdda_r[19]}}, audio.cdda_r};
	assign adpcm_x  = {{(MIX_W-20){audio.adpcm[15]}}, audio.adpcm, 4'b0000}; // x16

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			sum_l <= '0;
			sum_r <= '0;
		end else begin
			sum_l <= psg_l_x + cdda_l_x + adpcm_x;
			sum_r <= psg_r_x + cdda_r_x + adpcm_x;
		end
	end

	// Top 4 bits agree means the sum fits in 19 signed bits
	function automatic dac_word_t clamp(input logic [MIX_W-1:0] s);
		logic            sgn;
		logic [DAC_W-2:0] mag;
		sgn = s[MIX_W-1];
		if (s[MIX_W-1:DAC_W-1] == '0 || s[MIX_W-1:DAC_W-1] == '1)
			mag = s[DAC_W-2:0];
		else
			mag = {(DAC_W-1){~sgn}};
		return {~sgn, mag};  // Flip sign for offset binary
	endfunction

	assign dac_l = clamp(sum_l);
	assign dac_r = clamp(sum_r);

	// Positive overflow pins the converter at full scale
	a_clamp_hi: assert property (@(posedge clk_sys) disable iff (!rst_n)
		(!sum_l[MIX_W-1] && |sum_l[MIX_W-2:DAC_W-1]) |-> (&dac_l));

endmodule

// File: audio/audio_sd_dac.sv
// First-order delta-sigma one-bit converter for one channel
`timescale 1ns/1ps

module audio_sd_dac #(
	parameter int WIDTH = 19
) (
	input  logic             clk_sys,
	input  logic             rst_n,
	input  logic [WIDTH-1:0] din,   // Offset binary
	output logic             dout
);

	logic [WIDTH-1:0] acc;

	// Carry out of the accumulator is the pulse density output
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			acc  <= '0;
			dout <= 1'b0;
		end else begin
			{dout, acc} <= {1'b0, acc} + {1'b0, din};
		end
	end

endmodule

// File: rtl/pce_io_top.sv
// Top level of the console I/O glue: pad port and audio path
`timescale 1ns/1ps

module pce_io_top (
	input  logic                         clk_sys,
	input  logic                         rst_n,
	input  logic [pce_io_pkg::JOY_W-1:0] joy [pce_io_pkg::N_PADS],
	input  pce_io_pkg::pad_cfg_t         cfg,
	input  pce_io_pkg::mouse_pkt_t       mouse,
	input  logic                         mouse_strobe,
	input  pce_io_pkg::pad_ctrl_t        ctrl,
	output logic [3:0]                   joy_in,
	input  pce_io_pkg::audio_src_t       audio,
	output logic                         audio_l,
	output logic                         audio_r
);
	import pce_io_pkg::*;

	// ========================================
	// Pad block
	// ========================================
	pad_word_t  pads [N_PADS];
	logic [1:0] pad0_btn;  // Swapped player 1, bits 7:6
	logic [7:0] mouse_nib;

	pad_decode u_pad_decode (
		.joy      (joy),
		.cfg      (cfg),
		.pads     (pads),
		.pad0_btn (pad0_btn)
	);

	mouse_tracker u_mouse_tracker (
		.clk_sys      (clk_sys),
		.rst_n        (rst_n),
		.mouse        (mouse),
		.mouse_strobe (mouse_strobe),
		.ctrl         (ctrl),
		.pad0_btn     (pad0_btn),
		.mouse_nib    (mouse_nib)
	);

	pad_port_mux u_pad_port_mux (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.ctrl      (ctrl),
		.cfg       (cfg),
		.pads      (pads),
		.mouse_nib (mouse_nib),
		.joy_in    (joy_in)
	);

	// ========================================
	// Audio block
	// ========================================
	dac_word_t dac_l;
	dac_word_t dac_r;

	audio_mixer u_audio_mixer (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.audio   (audio),
		.dac_l   (dac_l),
		.dac_r   (dac_r)
	);

	audio_sd_dac #(.WIDTH(DAC_W)) u_dac_l (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.din     (dac_l),
		.dout    (audio_l)
	);

	audio_sd_dac #(.WIDTH(DAC_W)) u_dac_r (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.din     (dac_r),
		.dout    (audio_r)
	);

endmodule

// File: test/tb_pce_io.sv
// Testbench for pad port and audio path with stimulus, reference model, assertions and timeout
`timescale 1ns/1ps

module tb_pce_io;
	import pce_io_pkg::*;

	localparam int TO_MAX      = (1 << MOUSE_TO_W) - 1;
	localparam int HALF        = 1 << (DAC_W - 1);  // Offset of the converter word
	localparam int STIM_CYCLES = 1000;              // All phases but the timeout hold
	localparam int CYCLE_LIMIT = STIM_CYCLES + 40000;

	logic             clk_sys = 1'b0;
	logic             rst_n;
	logic             mouse_strobe;
	logic             audio_l;
	logic             audio_r;
	logic [JOY_W-1:0] joy [N_PADS];
	pad_cfg_t         cfg;
	mouse_pkt_t       mouse;
	pad_ctrl_t        ctrl;
	audio_src_t       audio;
	logic [3:0]       joy_in;
	logic [3:0]       exp_joy;
	logic [15:0]      lfsr = 16'd11103;
	int               cycle_cnt = 0;

	// Reference model state
	logic        ref_clr_q;
	logic        ref_sel_q;
	logic        ref_page;
	logic        ref_out_l;
	logic        ref_out_r;
	logic [2:0]  ref_port;
	logic [1:0]  ref_cnt;
	logic [7:0]  ref_pend_x;
	logic [7:0]  ref_pend_y;
	logic [7:0]  ref_shown_x;
	logic [7:0]  ref_shown_y;
	logic [18:0] ref_acc_l;
	logic [18:0] ref_acc_r;
	int          ref_to;
	int          ref_sum_l;
	int          ref_sum_r;

	pce_io_top dut0 (.*);

	always #20 clk_sys = ~clk_sys;

	// ========================================
	// Helpers
	// ========================================
	// Galois LFSR stepped once per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r    = {r[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
		end
		return r;
	endfunction

	function automatic logic [31:0] swapped_word(input int p);
		if (cfg.swap && p < 2)
			return joy[1 - p];
		return joy[p];
	endfunction

	// Slices run buttons, directions, extra buttons and zero
	function automatic logic [3:0] expected_nibble(input int port, input int idx);
		logic [31:0] raw;
		logic [7:0]  delta;
		if (port == 0 && cfg.mouse_en) begin
			raw   = swapped_word(0);
			delta = ref_cnt[1] ? ref_shown_y : ref_shown_x;
			if (idx % 2 == 0)
				return ~{raw[7:6], mouse.left, mouse.right};
			return ref_cnt[0] ? delta[3:0] : delta[7:4];
		end
		if (port >= N_PADS)
			return PAD_IDLE[idx*4 +: 4];
		raw = swapped_word(port);
		case (idx)
			0: return ~raw[7:4];
			1: return ~{raw[1], raw[2], raw[0], raw[3]};  // Left, down, right, up
			2: return ~raw[11:8];
			default: return 4'h0;
		endcase
	endfunction

	// Clamp to 19 bits in offset binary and take one accumulator step with carry on top
	function automatic logic [19:0] dac_step(input logic [18:0] acc, input int s);
		int d;
		d = (s > HALF - 1) ? 2 * HALF - 1 : ((s < -HALF) ? 0 : s + HALF);
		return 20'(int'(acc) + d);
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TESTBENCH FAILED");
		$fatal(1, "Run stopped");
	endtask

	task automatic value_error(input string msg);
		abort_run($sformatf("Error at %0d ns: %s", $time, msg));
	endtask

	task automatic next_cycle();
		@(posedge clk_sys);
		#2;
	endtask

	task automatic step_pads(input int n);
		repeat (n) begin
			for (int i = 0; i < N_PADS; i++)
				joy[i] = rand_bits(32);
			ctrl.sel = ~ctrl.sel;
			next_cycle();
		end
	endtask

	task automatic clr_pulse();
		ctrl = '{clr: 1'b1, sel: 1'b0};
		next_cycle();
		ctrl.clr = 1'b0;
		next_cycle();
	endtask

	task automatic send_mouse();
		logic [31:0] r;
		r            = rand_bits(18);
		mouse        = r[17:0];
		mouse_strobe = 1'b1;
		next_cycle();
		mouse_strobe = 1'b0;
	endtask

	// Four nibbles with each read as buttons then delta
	task automatic read_mouse();
		repeat (4) begin
			clr_pulse();
			ctrl.sel = 1'b1;
			next_cycle();
			ctrl.sel = 1'b0;
		end
		next_cycle();
	endtask

	// ========================================
	// Reference model
	// ========================================
	always @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			{ref_clr_q, ref_sel_q, ref_page, ref_port, exp_joy} <= '0;
			{ref_pend_x, ref_pend_y, ref_shown_x, ref_shown_y} <= '0;
			ref_cnt <= 2'd3;
			ref_to  <= 0;
		end else begin
			ref_clr_q <= ctrl.clr;
			ref_sel_q <= ctrl.sel;
			if (ctrl.clr)
				ref_to <= 0;
			else if (ref_to < TO_MAX)
				ref_to <= ref_to + 1;
			if (ctrl.clr) begin
				ref_port <= '0;
				exp_joy  <= 4'h0;
			end else begin
				exp_joy <= expected_nibble(int'(ref_port), int'({ref_page, ctrl.sel}));
				if (cfg.turbotap && ctrl.sel && !ref_sel_q)
					ref_port <= ref_port + 3'd1;
			end
			if (!cfg.buttons6)
				ref_page <= 1'b0;
			else if (ctrl.clr && !ref_clr_q)
				ref_page <= ~ref_page;
			if (ctrl.clr && !ref_clr_q) begin
				ref_cnt <= ref_cnt + 2'd1;
				if (ref_cnt == 2'd3) begin  // Sequence start shows the pending deltas
					ref_shown_x <= ref_pend_x;
					ref_shown_y <= ref_pend_y;
					ref_pend_x  <= '0;
					ref_pend_y  <= '0;
				end
			end else if (ref_to == TO_MAX) begin
				ref_cnt <= 2'd3;
			end
			if (mouse_strobe) begin
				ref_pend_x <= ~mouse.dx + 8'd1;  // Mirrored X
				ref_pend_y <= mouse.dy;
			end
		end
	end

	always @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			{ref_sum_l, ref_sum_r} <= '0;
			{ref_out_l, ref_acc_l, ref_out_r, ref_acc_r} <= '0;
		end else begin
			ref_sum_l <= int'($signed(audio.psg_l)) + int'($signed(audio.cdda_l))
				+ 16 * int'($signed(audio.adpcm));
			ref_sum_r <= int'($signed(audio.psg_r)) + int'($signed(audio.cdda_r))
				+ 16 * int'($signed(audio.adpcm));
			{ref_out_l, ref_acc_l} <= dac_step(ref_acc_l, ref_sum_l);
			{ref_out_r, ref_acc_r} <= dac_step(ref_acc_r, ref_sum_r);
		end
	end

	// ========================================
	// Checks and timeout
	// ========================================
	a_reset_quiet: assert property (@(posedge clk_sys)
		!rst_n |-> (joy_in == 4'h0 && !audio_l && !audio_r))
		else value_error("outputs not zero while reset is held");

	a_joy_in: assert property (@(posedge clk_sys) joy_in == exp_joy)
		else value_error($sformatf("joy_in is %h, expected %h",
			$sampled(joy_in), $sampled(exp_joy)));

	a_audio: assert property (@(posedge clk_sys) audio_l == ref_out_l && audio_r == ref_out_r)
		else value_error($sformatf("audio bits are %b%b, expected %b%b", $sampled(audio_l),
			$sampled(audio_r), $sampled(ref_out_l), $sampled(ref_out_r)));

	always @(posedge clk_sys) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= CYCLE_LIMIT)
			abort_run("The run did not finish within the cycle limit");
	end

	// ========================================
	// Stimulus
	// ========================================
	initial begin
		rst_n        = 1'b1;
		cfg          = '0;
		ctrl         = '0;
		mouse        = '0;
		mouse_strobe = 1'b0;
		audio        = '0;
		for (int i = 0; i < N_PADS; i++)
			joy[i] = '0;
		#1 rst_n = 1'b0;
		repeat (10) @(posedge clk_sys);
		#2 rst_n = 1'b1;

		step_pads(40);  // Pad map on port 0 without swap
		cfg.swap = 1'b1;
		step_pads(40);

		// Multitap walk with wrap and then six-button pages
		cfg = '{swap: 1'b0, turbotap: 1'b1, buttons6: 1'b0, mouse_en: 1'b0};
		clr_pulse();
		step_pads(18);
		cfg.buttons6 = 1'b1;
		repeat (6) begin
			clr_pulse();
			step_pads(2);
		end

		// Mouse sequences from a fresh start
		cfg = '{swap: 1'b0, turbotap: 1'b0, buttons6: 1'b0, mouse_en: 1'b1};
		while (ref_cnt != 2'd3)
			clr_pulse();
		repeat (4) begin
			send_mouse();
			read_mouse();
		end

		// Timeout after an abandoned read puts the next read back on x high
		clr_pulse();
		clr_pulse();
		send_mouse();
		repeat (TO_MAX + 4)
			next_cycle();
		read_mouse();

		repeat (200) begin
			audio = {rand_bits(32), rand_bits(32), rand_bits(32)};
			next_cycle();
		end
		audio = '{psg_l: 20'h7FFFF, psg_r: 20'h7FFFF, cdda_l: 20'h7FFFF,
			cdda_r: 20'h7FFFF, adpcm: 16'h7FFF};
		repeat (20)
			next_cycle();
		audio = '{psg_l: 20'h80000, psg_r: 20'h80000, cdda_l: 20'h80000,
			cdda_r: 20'h80000, adpcm: 16'h8000};
		repeat (20)
			next_cycle();
		// Just over the top on the left and exactly the bottom on the right
		audio = '{psg_l: 20'h3FFFF, psg_r: 20'hC0000, cdda_l: 20'h00001,
			cdda_r: 20'h00000, adpcm: 16'h0000};
		repeat (20)
			next_cycle();
		audio = '0;
		repeat (4)
			next_cycle();

		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

// File: tb.f
common/pce_io_pkg.sv
pad/pad_decode.sv
pad/mouse_tracker.sv
pad/pad_port_mux.sv
audio/audio_mixer.sv
audio/audio_sd_dac.sv
rtl/pce_io_top.sv
test/tb_pce_io.sv
